/* tb.f */
+incdir+verilog
verilog/lsu_pkg.sv
verilog/store_align.sv
verilog/data_ram.sv
verilog/load_extend.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/mmio_regs.sv
verilog/lsu_top.sv
tests/lsu_sva.sv
tests/lsu_tb.sv

/* tests/lsu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defs.svh"

module lsu_tb;
    import lsu_pkg::*;

    localparam int    clk_period = 10;
    localparam int    max_rows   = 64;
    localparam int    wait_limit = 16;
    // Two full frames of polling, each poll is two cycles
    localparam int    poll_limit = 10 * `LSU_CLKS_PER_BIT;
    localparam word_t dmem_base  = 32'h1000_0000;
    localparam word_t ctrl_addr  = `LSU_MMIO_BASE | 32'(`LSU_UART_CTRL);
    localparam word_t rx_addr    = `LSU_MMIO_BASE | 32'(`LSU_UART_RX);
    localparam word_t tx_addr    = `LSU_MMIO_BASE | 32'(`LSU_UART_TX);
    localparam word_t cnt_addr   = `LSU_MMIO_BASE | 32'(`LSU_CYCLE_CNT);
    localparam word_t clr_addr   = `LSU_MMIO_BASE | 32'(`LSU_CYCLE_RST);

    logic      clk;
    logic      rst;
    logic      req_valid;
    logic      req_store;
    mem_size_t req_size;
    word_t     req_addr;
    word_t     req_wdata;
    word_t     rdata;
    logic      rdata_valid;
    wire       serial_loop;

    // Operation table, one row per request
    logic      row_store [max_rows];
    mem_size_t row_size [max_rows];
    word_t     row_addr [max_rows];
    word_t     row_wdata [max_rows];
    word_t     row_expect [max_rows];
    int        row_count;
    // Expected RAM words, indexed by address bits 7:2
    word_t     shadow [64];
    integer    seed;
    int        checks;
    int        errors;
    time       req_time;

    // Serial line looped back onto itself
    lsu_top dut_i (
        .clk         (clk),
        .rst         (rst),
        .req_valid   (req_valid),
        .req_store   (req_store),
        .req_size    (req_size),
        .req_addr    (req_addr),
        .req_wdata   (req_wdata),
        .rdata       (rdata),
        .rdata_valid (rdata_valid),
        .serial_in   (serial_loop),
        .serial_out  (serial_loop)
    );

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    // Loaded field per RISC-V rules, the word shifted down to the addressed lane
    function automatic word_t expected_load(word_t w, mem_size_t size, logic [1:0] off);
        word_t shifted;
        shifted = w >> (8 * off);
        case (size)
            SIZE_B:  expected_load = {{24{shifted[7]}}, shifted[7:0]};
            SIZE_BU: expected_load = {24'd0, shifted[7:0]};
            SIZE_H:  expected_load = {{16{shifted[15]}}, shifted[15:0]};
            SIZE_HU: expected_load = {16'd0, shifted[15:0]};
            default: expected_load = w;
        endcase
    endfunction

    // Old word with the stored field laid over its lanes
    function automatic word_t merge_store(word_t old, mem_size_t size, logic [1:0] off,
                                          word_t data);
        word_t field;
        int    pos;
        field = (size == SIZE_B) ? 32'h0000_00FF : (size == SIZE_H) ? 32'h0000_FFFF : '1;
        // Halves sit on even lanes, words on lane 0
        pos = (size == SIZE_B) ? 8 * off : (size == SIZE_H) ? 16 * off[1] : 0;
        merge_store = (old & ~(field << pos)) | ((data & field) << pos);
    endfunction

    function automatic void add_row(logic store, mem_size_t size, word_t addr, word_t data,
                                    word_t exp);
        if (row_count < max_rows) begin
            row_store[row_count]  = store;
            row_size[row_count]   = size;
            row_addr[row_count]   = addr;
            row_wdata[row_count]  = data;
            row_expect[row_count] = exp;
            row_count++;
        end
    endfunction

    function automatic void add_store(mem_size_t size, word_t addr, word_t data);
        shadow[addr[7:2]] = merge_store(shadow[addr[7:2]], size, addr[1:0], data);
        add_row(1'b1, size, addr, data, '0);
    endfunction

    function automatic void add_load(mem_size_t size, word_t addr);
        add_row(1'b0, size, addr, '0, expected_load(shadow[addr[7:2]], size, addr[1:0]));
    endfunction

    // Every byte and half view of one word
    function automatic void add_extension_loads(word_t addr);
        for (int off = 0; off < 4; off++) begin
            add_load(SIZE_B, addr + 32'(off));
            add_load(SIZE_BU, addr + 32'(off));
        end
        for (int off = 0; off < 4; off += 2) begin
            add_load(SIZE_H, addr + 32'(off));
            add_load(SIZE_HU, addr + 32'(off));
        end
    endfunction

    function automatic void build_table();
        // Word round trip
        for (int i = 0; i < 4; i++) begin
            add_store(SIZE_W, dmem_base + 32'(4 * i), $random(seed));
            add_load(SIZE_W, dmem_base + 32'(4 * i));
        end
        // Partial stores, untouched lanes survive
        add_store(SIZE_W, dmem_base + 32'h40, $random(seed));
        add_store(SIZE_B, dmem_base + 32'h41, $random(seed));
        add_store(SIZE_H, dmem_base + 32'h42, $random(seed));
        add_load(SIZE_W, dmem_base + 32'h40);
        add_store(SIZE_W, dmem_base + 32'h44, $random(seed));
        add_store(SIZE_B, dmem_base + 32'h47, $random(seed));
        add_store(SIZE_H, dmem_base + 32'h44, $random(seed));
        add_load(SIZE_W, dmem_base + 32'h44);
        // Mixed sign bits in both halves and bytes
        add_store(SIZE_W, dmem_base + 32'h80, 32'h7E8F_F001);
        add_store(SIZE_W, dmem_base + 32'h84, $random(seed));
        add_extension_loads(dmem_base + 32'h80);
        add_extension_loads(dmem_base + 32'h84);
        // Unmapped space and MMIO holes
        add_row(1'b0, SIZE_W, 32'h0000_0100, '0, '0);
        add_row(1'b0, SIZE_W, 32'h2000_0000, '0, '0);
        add_row(1'b0, SIZE_W, 32'hC000_0010, '0, '0);
        add_row(1'b0, SIZE_W, `LSU_MMIO_BASE | 32'h0C, '0, '0);
        add_row(1'b0, SIZE_W, `LSU_MMIO_BASE | 32'h14, '0, '0);
        add_row(1'b0, SIZE_W, tx_addr, '0, '0);
        add_row(1'b0, SIZE_W, clr_addr, '0, '0);
        // Idle status, tx ready and nothing held
        add_row(1'b0, SIZE_W, ctrl_addr, '0, 32'h1);
    endfunction

    // One request cycle, launched on the falling edge
    task automatic issue(logic store, mem_size_t size, word_t addr, word_t data);
        @(negedge clk);
        req_valid = 1'b1;
        req_store = store;
        req_size  = size;
        req_addr  = addr;
        req_wdata = data;
        req_time  = $time;
        @(negedge clk);
        req_valid = 1'b0;
        req_store = 1'b0;
    endtask

    // Data is due at the first falling edge after the request edge
    task automatic load_word(mem_size_t size, word_t addr, output word_t value,
                             output logic ok);
        int waited;
        issue(1'b0, size, addr, '0);
        waited = 0;
        while (!rdata_valid && waited < wait_limit) begin
            @(negedge clk);
            waited++;
        end
        ok    = rdata_valid;
        value = rdata;
        if (!ok) begin
            $display("Timed out waiting for load data from address %h", addr);
            errors++;
        end else if (waited != 0) begin
            $display("Load data from address %h came %0d cycles late", addr, waited);
            errors++;
        end
    endtask

    task automatic check_value(string what, word_t got, word_t exp);
        checks++;
        assert (got === exp) else begin
            $display("[FAIL] %0t ns: %s returned %h, expected %h", $time, what, got, exp);
            errors++;
        end
        $display("%-36s %s", what, (got === exp) ? "ok" : "mismatch");
    endtask

    task automatic run_table();
        word_t got;
        logic  ok;
        for (int i = 0; i < row_count; i++) begin
            if (row_store[i]) begin
                issue(1'b1, row_size[i], row_addr[i], row_wdata[i]);
            end else begin
                load_word(row_size[i], row_addr[i], got, ok);
                if (ok) begin
                    check_value($sformatf("row %0d %s load %h", i, row_size[i].name(),
                                          row_addr[i]), got, row_expect[i]);
                end
            end
        end
    endtask

    // Byte out on the TX pin, back in on the RX pin
    task automatic uart_loopback(logic [7:0] tx_byte);
        word_t value;
        logic  ok;
        int    polls;
        // Sends while busy are dropped
        // Poll for tx ready first
        value = '0;
        ok    = 1'b1;
        polls = 0;
        while (ok && !value[0] && polls < poll_limit) begin
            load_word(SIZE_W, ctrl_addr, value, ok);
            polls++;
        end
        if (ok && !value[0]) begin
            $display("Transmitter never became ready, byte %h was not sent", tx_byte);
            errors++;
            ok = 1'b0;
        end
        if (ok) begin
            issue(1'b1, SIZE_B, tx_addr, {24'd0, tx_byte});
            load_word(SIZE_W, ctrl_addr, value, ok);
        end
        if (ok) begin
            check_value("uart status busy after send", value & 32'h1, 32'h0);
        end
        value = '0;
        polls = 0;
        while (ok && !value[1] && polls < poll_limit) begin
            load_word(SIZE_W, ctrl_addr, value, ok);
            polls++;
        end
        if (ok && !value[1]) begin
            $display("Receive flag never rose, looped back byte was lost");
            errors++;
        end else if (ok) begin
            load_word(SIZE_W, rx_addr, value, ok);
            if (ok) begin
                check_value($sformatf("uart loopback byte %h", tx_byte), value,
                            {24'd0, tx_byte});
            end
            load_word(SIZE_W, ctrl_addr, value, ok);
            if (ok) begin
                check_value("uart rx flag cleared by read", value & 32'h2, 32'h0);
            end
        end
    endtask

    // Counter reads zero the cycle after the clear, then counts every cycle
    task automatic cycle_spacing(int gap);
        word_t first;
        word_t second;
        logic  ok_first;
        logic  ok_second;
        time   t_clear;
        time   t_first;
        int    spacing;
        issue(1'b1, SIZE_W, clr_addr, '0);
        t_clear = req_time;
        load_word(SIZE_W, cnt_addr, first, ok_first);
        t_first = req_time;
        repeat (gap) @(negedge clk);
        load_word(SIZE_W, cnt_addr, second, ok_second);
        spacing = int'((req_time - t_first) / clk_period);
        if (ok_first) begin
            check_value("cycle count after clear", first,
                        word_t'((t_first - t_clear) / clk_period - 1));
        end
        if (ok_first && ok_second) begin
            check_value($sformatf("cycle count over %0d cycles", spacing), second - first,
                        word_t'(spacing));
        end
    endtask

    initial begin
        seed      = 34832;
        checks    = 0;
        errors    = 0;
        row_count = 0;
        rst       = 1'b1;
        req_valid = 1'b0;
        req_store = 1'b0;
        req_size  = SIZE_W;
        req_addr  = '0;
        req_wdata = '0;
        req_time  = 0;
        foreach (shadow[i]) shadow[i] = '0;
        build_table();
        repeat (5) @(negedge clk);
        rst = 1'b0;
        run_table();
        uart_loopback(8'($random(seed)));
        uart_loopback(8'h81);
        cycle_spacing(37);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/lsu_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_sva (
    input logic clk,
    input logic rst,
    input logic req_valid,
    input logic req_store,
    input logic rdata_valid,
    input logic serial_out,
    input logic tx_ready,
    input logic tx_valid
);
    logic load_req;

    assign load_req = req_valid && !req_store;

    // Load data comes back exactly one cycle after the request
    load_returns: assert property (@(posedge clk) disable iff (rst) load_req |=> rdata_valid)
        else $error("rdata_valid missing one cycle after a load request");

    // No return without a load in the cycle before
    no_stray_valid: assert property (@(posedge clk) disable iff (rst)
        rdata_valid |-> $past(load_req))
        else $error("rdata_valid without a load request in the previous cycle");

    // Idle transmitter holds the line high
    line_idle_high: assert property (@(posedge clk) disable iff (rst) tx_ready |-> serial_out)
        else $error("serial_out low while the transmitter is idle");

    // Sends are gated while a frame is on the line
    no_send_busy: assert property (@(posedge clk) disable iff (rst) !tx_ready |-> !tx_valid)
        else $error("tx_valid raised while the transmitter is busy");

endmodule

bind lsu_top lsu_sva lsu_sva_i (
    .clk         (clk),
    .rst         (rst),
    .req_valid   (req_valid),
    .req_store   (req_store),
    .rdata_valid (rdata_valid),
    .serial_out  (serial_out),
    .tx_ready    (tx_ready),
    .tx_valid    (tx_valid)
);

`default_nettype wire

/* verilog/lsu_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defs.svh"

module lsu_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               req_valid,
    input  logic               req_store,
    input  lsu_pkg::mem_size_t req_size,
    input  lsu_pkg::word_t     req_addr,
    input  lsu_pkg::word_t     req_wdata,
    output lsu_pkg::word_t     rdata,
    output logic               rdata_valid,
    input  logic               serial_in,
    output logic               serial_out
);
    import lsu_pkg::*;

    localparam word_t mmio_base = `LSU_MMIO_BASE;

    region_t    req_region;
    region_t    region_q;
    logic       load_q;
    byte_mask_t st_mask;
    word_t      st_data;
    logic       dmem_en;
    byte_mask_t dmem_we;
    word_t      dmem_dout;
    word_t      dmem_value;
    logic       mmio_sel;
    word_t      mmio_rdata;
    logic [7:0] tx_data;
    logic       tx_valid;
    logic       tx_ready;
    logic [7:0] rx_data;
    logic       rx_valid;
    logic       rx_ready;

    // Address map
    always_comb begin
        if (req_addr[31:30] == 2'b00 && req_addr[28]) begin
            req_region = REGION_DMEM;
        end else if (req_addr[31:28] == mmio_base[31:28]) begin
            req_region = REGION_MMIO;
        end else begin
            req_region = REGION_NONE;
        end
    end

    // Steer the request, unmapped ones touch nothing
    assign dmem_en  = req_valid && (req_region == REGION_DMEM);
    assign dmem_we  = (dmem_en && req_store) ? st_mask : 4'b0000;
    assign mmio_sel = req_valid && (req_region == REGION_MMIO);

    store_align store_align_i (
        .size          (req_size),
        .offset        (req_addr[1:0]),
        .wdata         (req_wdata),
        .mask          (st_mask),
        .wdata_aligned (st_data)
    );

    data_ram data_ram_i (
        .clk  (clk),
        .en   (dmem_en),
        .we   (dmem_we),
        .addr (req_addr[`LSU_DMEM_WORDS_LOG2+1:2]),
        .din  (st_data),
        .dout (dmem_dout)
    );

    load_extend load_extend_i (
        .clk      (clk),
        .rst      (rst),
        .capture  (dmem_en && !req_store),
        .size     (req_size),
        .offset   (req_addr[1:0]),
        .ram_word (dmem_dout),
        .value    (dmem_value)
    );

    mmio_regs mmio_regs_i (
        .clk      (clk),
        .rst      (rst),
        .sel      (mmio_sel),
        .store    (req_store),
        .offset   (req_addr[7:0]),
        .wbyte    (req_wdata[7:0]),
        .tx_ready (tx_ready),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .rx_ready (rx_ready),
        .rdata    (mmio_rdata)
    );

    uart_tx uart_tx_i (
        .clk        (clk),
        .rst        (rst),
        .tx_data    (tx_data),
        .tx_valid   (tx_valid),
        .tx_ready   (tx_ready),
        .serial_out (serial_out)
    );

    uart_rx uart_rx_i (
        .clk       (clk),
        .rst       (rst),
        .serial_in (serial_in),
        .rx_ready  (rx_ready),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid)
    );

    // Load return tracks the request by one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            load_q   <= 1'b0;
            region_q <= REGION_NONE;
        end else begin
            load_q   <= req_valid && !req_store;
            region_q <= req_region;
        end
    end

    assign rdata_valid = load_q;

    // Unmapped loads come back as zero
    always_comb begin
        case (region_q)
            REGION_DMEM: rdata = dmem_value;
            REGION_MMIO: rdata = mmio_rdata;
            default:     rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/mmio_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defs.svh"

module mmio_regs (
    input  logic           clk,
    input  logic           rst,
    input  logic           sel,
    input  logic           store,
    input  logic [7:0]     offset,
    input  logic [7:0]     wbyte,
    input  logic           tx_ready,
    input  logic [7:0]     rx_data,
    input  logic           rx_valid,
    output logic [7:0]     tx_data,
    output logic           tx_valid,
    output logic           rx_ready,
    output lsu_pkg::word_t rdata
);
    import lsu_pkg::*;

    logic  is_load;
    logic  is_store;
    logic  cycle_clr;
    word_t cycle_cnt;
    word_t read_word;

    assign is_load  = sel && !store;
    assign is_store = sel && store;

    // TX register, write only
    // Dropped while the transmitter is busy, software polls status
    assign tx_data  = wbyte;
    assign tx_valid = is_store && (offset == `LSU_UART_TX) && tx_ready;

    // Reading the RX register consumes the byte
    assign rx_ready = is_load && (offset == `LSU_UART_RX);

    assign cycle_clr = is_store && (offset == `LSU_CYCLE_RST);

    // Free-running cycle counter
    always_ff @(posedge clk) begin
        if (rst || cycle_clr) begin
            cycle_cnt <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 32'd1;
        end
    end

    // Read mux
    always_comb begin
        case (offset)
            `LSU_UART_CTRL: read_word = {30'd0, rx_valid, tx_ready};
            // Full word, no extension
            `LSU_UART_RX:   read_word = {24'd0, rx_data};
            `LSU_CYCLE_CNT: read_word = cycle_cnt;
            // TX, reset address and holes read zero
            default:        read_word = '0;
        endcase
    end

    // One cycle of read latency, matches the RAM
    always_ff @(posedge clk) begin
        if (is_load) begin
            rdata <= read_word;
        end
    end

endmodule

`default_nettype wire

/* verilog/uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defs.svh"

module uart_rx (
    input  logic       clk,
    input  logic       rst,
    input  logic       serial_in,
    input  logic       rx_ready,
    output logic [7:0] rx_data,
    output logic       rx_valid
);
    localparam int clks_per_bit = `LSU_CLKS_PER_BIT;
    localparam int half_bit = clks_per_bit / 2;
    localparam int cnt_w = $clog2(clks_per_bit);

    logic [1:0]       sync_q;
    logic             rx_s;
    logic             rx_prev;
    logic             busy;
    logic             sample;
    logic [cnt_w-1:0] bit_cnt;
    // 0 start bit, 1 to 8 data, 9 stop
    logic [3:0]       bit_idx;
    logic [7:0]       shift;

    // Line after the two-flop synchronizer
    assign rx_s   = sync_q[1];
    // Mid-bit strobe
    assign sample = busy && (bit_cnt == cnt_w'(half_bit));

    always_ff @(posedge clk) begin
        if (rst) begin
            sync_q   <= 2'b11;
            rx_prev  <= 1'b1;
            busy     <= 1'b0;
            bit_cnt  <= '0;
            bit_idx  <= 4'd0;
            rx_valid <= 1'b0;
        end else begin
            sync_q  <= {sync_q[0], serial_in};
            rx_prev <= rx_s;

            if (!busy) begin
                // Falling edge opens a frame
                if (rx_prev && !rx_s) begin
                    busy    <= 1'b1;
                    bit_cnt <= '0;
                    bit_idx <= 4'd0;
                end
            end else begin
                bit_cnt <= (bit_cnt == cnt_w'(clks_per_bit - 1)) ? '0 : bit_cnt + 1'b1;
                if (sample) begin
                    bit_idx <= bit_idx + 4'd1;
                    // Start bit high at mid-bit means a glitch
                    if ((bit_idx == 4'd0 && rx_s) || bit_idx == 4'd9) begin
                        busy <= 1'b0;
                    end
                end
            end

            // New byte wins over a clear in the same cycle
            if (sample && bit_idx == 4'd9) begin
                rx_valid <= 1'b1;
            end else if (rx_ready) begin
                rx_valid <= 1'b0;
            end
        end
    end

    // Data path, LSB first on the line
    always_ff @(posedge clk) begin
        if (sample && bit_idx >= 4'd1 && bit_idx <= 4'd8) begin
            shift <= {rx_s, shift[7:1]};
        end
        // Overwrites any unread byte
        if (sample && bit_idx == 4'd9) begin
            rx_data <= shift;
        end
    end

endmodule

`default_nettype wire

/* verilog/uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defs.svh"

module uart_tx (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] tx_data,
    input  logic       tx_valid,
    output logic       tx_ready,
    output logic       serial_out
);
    localparam int clks_per_bit = `LSU_CLKS_PER_BIT;
    localparam int cnt_w = $clog2(clks_per_bit);

    logic             busy;
    logic             start;
    logic             bit_done;
    logic [cnt_w-1:0] bit_cnt;
    // Bits still to put on the line after the current one
    logic [3:0]       bits_left;
    // Data bits then the stop bit, LSB goes out next
    logic [8:0]       shift;

    assign tx_ready = !busy;
    // Requests while busy are dropped
    assign start    = tx_valid && !busy;
    assign bit_done = busy && (bit_cnt == cnt_w'(clks_per_bit - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            busy       <= 1'b0;
            serial_out <= 1'b1;
            bit_cnt    <= '0;
            bits_left  <= 4'd0;
        end else if (start) begin
            // Start bit goes out right away
            busy       <= 1'b1;
            serial_out <= 1'b0;
            bit_cnt    <= '0;
            bits_left  <= 4'd9;
        end else if (bit_done) begin
            bit_cnt <= '0;
            if (bits_left == 4'd0) begin
                // Stop bit done, line already idles high
                busy <= 1'b0;
            end else begin
                serial_out <= shift[0];
                bits_left  <= bits_left - 4'd1;
            end
        end else if (busy) begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // Frame shifter
    always_ff @(posedge clk) begin
        if (start) begin
            shift <= {1'b1, tx_data};
        end else if (bit_done) begin
            shift <= {1'b1, shift[8:1]};
        end
    end

endmodule

`default_nettype wire

/* verilog/load_extend.sv */
`timescale 1ns/1ps
`default_nettype none

module load_extend (
    input  logic               clk,
    input  logic               rst,
    input  logic               capture,
    input  lsu_pkg::mem_size_t size,
    input  logic [1:0]         offset,
    input  lsu_pkg::word_t     ram_word,
    output lsu_pkg::word_t     value
);
    import lsu_pkg::*;

    mem_size_t  size_q;
    logic [1:0] offset_q;
    logic [7:0] byte_sel;
    logic [15:0] half_sel;

    // Hold the access shape until the RAM word shows up
    always_ff @(posedge clk) begin
        if (rst) begin
            size_q   <= SIZE_W;
            offset_q <= 2'b00;
        end else if (capture) begin
            size_q   <= size;
            offset_q <= offset;
        end
    end

    // Addressed byte and half of the returned word
    assign byte_sel = ram_word[8*offset_q +: 8];
    assign half_sel = offset_q[1] ? ram_word[31:16] : ram_word[15:0];

    always_comb begin
        case (size_q)
            // Signed, copy the top bit of the field
            SIZE_B:  value = {{24{byte_sel[7]}}, byte_sel};
            SIZE_H:  value = {{16{half_sel[15]}}, half_sel};
            // Unsigned, pad with zeros
            SIZE_BU: value = {24'h000000, byte_sel};
            SIZE_HU: value = {16'h0000, half_sel};
            // Full word passes through
            default: value = ram_word;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/data_ram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defs.svh"

module data_ram (
    input  logic                            clk,
    input  logic                            en,
    input  lsu_pkg::byte_mask_t             we,
    input  logic [`LSU_DMEM_WORDS_LOG2-1:0] addr,
    input  lsu_pkg::word_t                  din,
    output lsu_pkg::word_t                  dout
);
    import lsu_pkg::*;

    localparam int depth = 1 << `LSU_DMEM_WORDS_LOG2;

    word_t mem [0:depth-1];

    // Byte-lane writes, read of the old word on the same edge
    always_ff @(posedge clk) begin
        if (en) begin
            for (int i = 0; i < 4; i++) begin
                if (we[i]) begin
                    mem[addr][8*i +: 8] <= din[8*i +: 8];
                end
            end
            // Read port only moves on enabled cycles
            dout <= mem[addr];
        end
    end

endmodule

`default_nettype wire

/* verilog/store_align.sv */
`timescale 1ns/1ps
`default_nettype none

module store_align (
    input  lsu_pkg::mem_size_t  size,
    input  logic [1:0]          offset,
    input  lsu_pkg::word_t      wdata,
    output lsu_pkg::byte_mask_t mask,
    output lsu_pkg::word_t      wdata_aligned
);
    import lsu_pkg::*;

    // Lane enables from size and low address bits
    always_comb begin
        case (size)
            // One lane, picked by the full offset
            SIZE_B:  mask = byte_mask_t'(4'b0001 << offset);
            // Lane pair, upper or lower half
            SIZE_H:  mask = offset[1] ? 4'b1100 : 4'b0011;
            SIZE_W:  mask = 4'b1111;
            // Unsigned codes are not store sizes, write nothing
            default: mask = 4'b0000;
        endcase
    end

    // Copy the low data into every lane
    // Whatever lanes the mask opens then carry the right bytes
    always_comb begin
        case (size)
            SIZE_B:  wdata_aligned = {4{wdata[7:0]}};
            SIZE_H:  wdata_aligned = {2{wdata[15:0]}};
            default: wdata_aligned = wdata;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

    // Data and address word
    typedef logic [31:0] word_t;

    // One enable per byte lane, bit i is lane i
    typedef logic [3:0] byte_mask_t;

    // Access size, same codes as the RISC-V funct3 field
    typedef enum logic [2:0] {
        SIZE_B  = 3'b000,
        SIZE_H  = 3'b001,
        SIZE_W  = 3'b010,
        SIZE_BU = 3'b100,
        SIZE_HU = 3'b101
    } mem_size_t;

    // Target of a request
    // DMEM when addr[31:30] is 00 and addr[28] is set
    // MMIO when the top nibble is 1000
    typedef enum logic [1:0] {
        REGION_NONE = 2'd0,
        REGION_DMEM = 2'd1,
        REGION_MMIO = 2'd2
    } region_t;

endpackage

`default_nettype wire

/* verilog/lsu_defs.svh */
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// System clock and serial line rate
`define LSU_CLOCK_FREQ 50_000_000
`define LSU_BAUD_RATE 115_200

// Cycles per serial bit, 434 at the rates above
`define LSU_CLKS_PER_BIT (`LSU_CLOCK_FREQ / `LSU_BAUD_RATE)

// Word-address width of the data RAM, 16K words
`define LSU_DMEM_WORDS_LOG2 14

// MMIO window base, decoded on the top nibble
`define LSU_MMIO_BASE 32'h8000_0000

// MMIO register offsets, low address byte
// UART status, bit 0 tx ready, bit 1 rx valid
`define LSU_UART_CTRL 8'h00
// Received byte
`define LSU_UART_RX 8'h04
// Byte to send
`define LSU_UART_TX 8'h08
// Free-running cycle count
`define LSU_CYCLE_CNT 8'h10
// Any store here zeroes the cycle count
`define LSU_CYCLE_RST 8'h18

`endif
